// ==== mlpAccelerator.f ====
src/nnPkg.sv
src/neuronNode.sv
src/denseLayer.sv
src/inferenceControl.sv
src/apbRegisterFile.sv
src/mlpAccelerator.sv
+incdir+testbench
testbench/mlpAcceleratorTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module mlpAcceleratorTb -f mlpAccelerator.f -o mlpAcceleratorSim

./obj_dir/mlpAcceleratorSim

// ==== testbench/mlpModel.svh ====
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsrNext(logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// Negative sums give zero, large sums full scale, the rest keep bits 12 down to 5
function automatic logic [7:0] rectify(int sum);
	int scaled;
	scaled = sum >>> nnPkg::FracShift;
	if (sum < 0)
	begin
		return 8'd0;
	end
	else if (sum >= nnPkg::SatLimit)
	begin
		return 8'd255;
	end
	return scaled[7:0];
endfunction

function automatic logic [NumHidden-1:0][7:0] hiddenModel(logic [NumInputs-1:0][7:0] acts);
	logic [NumHidden-1:0][7:0] hidden;
	int sum;
	for (int n = 0; n < NumHidden; n++)
	begin
		sum = int'(signed'(HiddenBiases[n]));
		for (int i = 0; i < NumInputs; i++)
		begin
			sum += int'(acts[i]) * int'(signed'(HiddenWeights[n][i]));
		end
		hidden[n] = rectify(sum);
	end
	return hidden;
endfunction

function automatic int outputSum(logic [NumInputs-1:0][7:0] acts, int k);
	logic [NumHidden-1:0][7:0] hidden;
	int sum;
	hidden = hiddenModel(acts);
	sum = int'(signed'(OutputBiases[k]));
	for (int n = 0; n < NumHidden; n++)
	begin
		sum += int'(hidden[n]) * int'(signed'(OutputWeights[k][n]));
	end
	return sum;
endfunction

function automatic logic [NumOutputs-1:0][7:0] networkModel(logic [NumInputs-1:0][7:0] acts);
	logic [NumOutputs-1:0][7:0] outs;
	for (int k = 0; k < NumOutputs; k++)
	begin
		outs[k] = rectify(outputSum(acts, k));
	end
	return outs;
endfunction

`endif

// ==== testbench/mlpAcceleratorTb.sv ====
`default_nettype none

module mlpAcceleratorTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumInputs = 4;
	localparam int NumHidden = 4;
	localparam int NumOutputs = 2;
	localparam int RandomVectors = 60;
	// Four directed vectors, the random ones and the busy test
	localparam int TimeoutCycles = 200 * (4 + RandomVectors + 1) + 1000;

	// Rows run from the highest neuron down, each from its highest input down
	localparam logic [NumHidden-1:0][NumInputs-1:0][nnPkg::AccWidth-1:0] HiddenWeights = {
		24'sd22, -24'sd14, 24'sd9, 24'sd5,
		24'sd12, 24'sd7, -24'sd18, 24'sd29,
		-24'sd6, 24'sd18, 24'sd25, -24'sd12,
		24'sd8, -24'sd10, 24'sd15, 24'sd20
	};
	localparam logic [NumHidden-1:0][nnPkg::AccWidth-1:0] HiddenBiases = {
		-24'sd1, 24'sd2, -24'sd3, 24'sd4
	};
	localparam logic [NumOutputs-1:0][NumHidden-1:0][nnPkg::AccWidth-1:0] OutputWeights = {
		24'sd14, -24'sd8, 24'sd10, -24'sd15,
		-24'sd9, 24'sd29, 24'sd12, 24'sd18
	};
	localparam logic [NumOutputs-1:0][nnPkg::AccWidth-1:0] OutputBiases = {-24'sd2, 24'sd3};

	logic clk;
	logic reset;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	bit checkRead;
	logic [31:0] expRead;
	bit expErr;
	string testName;
	int cycleCount;
	logic [31:0] lfsrState;

	`include "mlpModel.svh"

	mlpAccelerator #(
		.NumInputs(NumInputs),
		.NumHidden(NumHidden),
		.NumOutputs(NumOutputs),
		.HiddenWeights(HiddenWeights),
		.HiddenBiases(HiddenBiases),
		.OutputWeights(OutputWeights),
		.OutputBiases(OutputBiases)
	) uut (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
		begin
			$display("Timeout after %0d cycles before the tests finished", cycleCount);
			$display("TESTS FAILED");
			$fatal(1, "Timeout");
		end
	end

	readValue: assert property (@(posedge clk) disable iff (reset)
		(psel && penable && !pwrite && checkRead) |-> (prdata == expRead))
		else
		begin
			$display("** Error: %s expected %h actual %h", testName, $sampled(expRead),
				$sampled(prdata));
			$display("TESTS FAILED");
			$fatal(1, "Read data mismatch");
		end

	errorFlag: assert property (@(posedge clk) disable iff (reset)
		(psel && penable) |-> (pslverr == expErr))
		else
		begin
			$display("** Error: %s expected pslverr %0b actual %0b", testName, $sampled(expErr),
				$sampled(pslverr));
			$display("TESTS FAILED");
			$fatal(1, "Error response mismatch");
		end

	readyHigh: assert property (@(posedge clk) disable iff (reset)
		(psel && penable) |-> pready)
		else
		begin
			$display("The slave held pready low during an access phase in %s", testName);
			$display("TESTS FAILED");
			$fatal(1, "Wait state seen");
		end

	// One transfer with setup and access phases, then one idle cycle
	task automatic apbAccess(input string name, input bit write, input logic [7:0] addr,
		input logic [31:0] data, input bit compareRead, input logic [7:0] readExpected,
		input bit errExpected, output logic [31:0] readData);
		@(posedge clk);
		testName <= name;
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		checkRead <= compareRead;
		expRead <= {24'h0, readExpected};
		expErr <= errExpected;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		readData = prdata;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic writeReg(input string name, input logic [7:0] addr, input logic [31:0] data,
		input bit errExpected);
		logic [31:0] ignored;
		apbAccess(name, 1'b1, addr, data, 1'b0, 8'd0, errExpected, ignored);
	endtask

	task automatic readReg(input string name, input logic [7:0] addr, input bit compareRead,
		input logic [7:0] expected, input bit errExpected);
		logic [31:0] ignored;
		apbAccess(name, 1'b0, addr, 32'd0, compareRead, expected, errExpected, ignored);
	endtask

	function automatic logic [7:0] inputAddr(int index);
		return 8'(int'(nnPkg::RegIn0) + 4 * index);
	endfunction

	function automatic logic [7:0] drawByte();
		logic [7:0] value;
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
		return value;
	endfunction

	task automatic startInference(input string name, input logic [NumInputs-1:0][7:0] vec);
		for (int i = 0; i < NumInputs; i++)
		begin
			writeReg(name, inputAddr(i), {24'h0, vec[i]}, 1'b0);
		end
		writeReg(name, nnPkg::RegControl, 32'd1, 1'b0);
	endtask

	// Polls status until done, then compares both outputs with the model
	task automatic checkResult(input string name, input logic [NumInputs-1:0][7:0] vec);
		logic [31:0] status;
		logic [NumOutputs-1:0][7:0] expected;
		expected = networkModel(vec);
		do
		begin
			apbAccess("status poll", 1'b0, nnPkg::RegStatus, 32'd0, 1'b0, 8'd0, 1'b0, status);
		end
		while (!status[1]);
		readReg(name, nnPkg::RegOut0, 1'b1, expected[0], 1'b0);
		readReg(name, nnPkg::RegOut1, 1'b1, expected[1], 1'b0);
	endtask

	initial
	begin
		logic [NumInputs-1:0][7:0] vec;
		logic [NumInputs-1:0][7:0] busyVec;
		logic [3:0][NumInputs-1:0][7:0] directed;
		logic [NumOutputs-1:0][7:0] lastOut;
		clk = 1'b0;
		reset <= 1'b1;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		checkRead <= 1'b0;
		expRead <= '0;
		expErr <= 1'b0;
		cycleCount = 0;
		lfsrState = 32'h90a1;
		testName = "reset";
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		readReg("reset status", nnPkg::RegStatus, 1'b1, 8'd0, 1'b0);
		readReg("reset control", nnPkg::RegControl, 1'b1, 8'd0, 1'b0);
		for (int i = 0; i < NumInputs; i++)
		begin
			readReg("reset input", inputAddr(i), 1'b1, 8'd0, 1'b0);
		end
		readReg("reset output", nnPkg::RegOut0, 1'b1, 8'd0, 1'b0);
		readReg("reset output", nnPkg::RegOut1, 1'b1, 8'd0, 1'b0);

		vec = {8'hFE, 8'h01, 8'hC3, 8'h5A};
		for (int i = 0; i < NumInputs; i++)
		begin
			writeReg("readback", inputAddr(i), {24'h0, vec[i]}, 1'b0);
		end
		for (int i = 0; i < NumInputs; i++)
		begin
			readReg("readback", inputAddr(i), 1'b1, vec[i], 1'b0);
		end

		// Saturated and negative outputs, all zero, and two linear-range vectors
		directed[0] = {8'd255, 8'd255, 8'd255, 8'd255};
		directed[1] = {8'd8, 8'd5, 8'd20, 8'd10};
		directed[2] = {8'd0, 8'd0, 8'd0, 8'd0};
		directed[3] = {8'd0, 8'd0, 8'd255, 8'd0};
		for (int k = 0; k < 4; k++)
		begin
			startInference("directed", directed[k]);
			checkResult("directed", directed[k]);
		end

		for (int r = 0; r < RandomVectors; r++)
		begin
			for (int i = 0; i < NumInputs; i++)
			begin
				vec[i] = drawByte();
			end
			startInference("random", vec);
			checkResult("random", vec);
		end

		busyVec = {8'd200, 8'd17, 8'd90, 8'd40};
		startInference("busy", busyVec);
		writeReg("input write while busy", inputAddr(2), 32'hAA, 1'b1);
		writeReg("start while busy", nnPkg::RegControl, 32'd1, 1'b0);
		checkResult("busy", busyVec);
		readReg("input kept while busy", inputAddr(2), 1'b1, busyVec[2], 1'b0);
		// A second accepted start would clear done or raise busy here
		repeat (8)
		begin
			readReg("done set once", nnPkg::RegStatus, 1'b1, 8'd2, 1'b0);
		end

		lastOut = networkModel(busyVec);
		writeReg("unmapped write", 8'h08, 32'd1, 1'b1);
		readReg("unmapped read", 8'h30, 1'b0, 8'd0, 1'b1);
		writeReg("status write", nnPkg::RegStatus, 32'd3, 1'b1);
		writeReg("output write", nnPkg::RegOut0, 32'hFF, 1'b1);
		readReg("status after errors", nnPkg::RegStatus, 1'b1, 8'd2, 1'b0);
		readReg("output after errors", nnPkg::RegOut0, 1'b1, lastOut[0], 1'b0);
		readReg("output after errors", nnPkg::RegOut1, 1'b1, lastOut[1], 1'b0);
		for (int i = 0; i < NumInputs; i++)
		begin
			readReg("input after errors", inputAddr(i), 1'b1, busyVec[i], 1'b0);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/mlpAccelerator.sv ====
`default_nettype none

module mlpAccelerator #(
	parameter int NumInputs = 4,
	parameter int NumHidden = 4,
	parameter int NumOutputs = 2,
	// Rows are listed from the highest neuron down, each row from its highest input down
	parameter logic [NumHidden-1:0][NumInputs-1:0][nnPkg::AccWidth-1:0] HiddenWeights = {
		24'sd9, -24'sd12, 24'sd29, 24'sd1,
		-24'sd3, 24'sd16, 24'sd4, -24'sd5,
		24'sd17, -24'sd11, 24'sd6, 24'sd10,
		-24'sd18, 24'sd13, 24'sd15, -24'sd7
	},
	parameter logic [NumHidden-1:0][nnPkg::AccWidth-1:0] HiddenBiases = {
		24'sd3, -24'sd2, 24'sd5, 24'sd1
	},
	parameter logic [NumOutputs-1:0][NumHidden-1:0][nnPkg::AccWidth-1:0] OutputWeights = {
		24'sd15, -24'sd6, 24'sd9, 24'sd13,
		-24'sd8, 24'sd18, 24'sd4, -24'sd3
	},
	parameter logic [NumOutputs-1:0][nnPkg::AccWidth-1:0] OutputBiases = {
		-24'sd4, 24'sd2
	}
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [nnPkg::AddrWidth-1:0] paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [nnPkg::DataWidth-1:0] pwdata,
	output logic [nnPkg::DataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic startPulse;
	logic busy;
	logic done;
	logic launchValid;
	logic hiddenValid;
	logic resultValid;
	logic [NumInputs*nnPkg::ActWidth-1:0] inputVector;
	logic [NumHidden*nnPkg::ActWidth-1:0] hiddenVector;
	logic [NumOutputs*nnPkg::ActWidth-1:0] resultVector;
	logic [NumOutputs*nnPkg::ActWidth-1:0] outputVector;

	apbRegisterFile #(
		.NumInputs(NumInputs),
		.NumOutputs(NumOutputs)
	) regFile (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.busy(busy),
		.done(done),
		.outputVector(outputVector),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.startPulse(startPulse),
		.inputVector(inputVector)
	);

	inferenceControl #(
		.NumOutputs(NumOutputs)
	) control (
		.clk(clk),
		.reset(reset),
		.startPulse(startPulse),
		.resultValid(resultValid),
		.resultVector(resultVector),
		.launchValid(launchValid),
		.busy(busy),
		.done(done),
		.outputVector(outputVector)
	);

	denseLayer #(
		.NumIn(NumInputs),
		.NumOut(NumHidden),
		.Weights(HiddenWeights),
		.Biases(HiddenBiases)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(launchValid),
		.inVector(inputVector),
		.outVector(hiddenVector),
		.outValid(hiddenValid)
	);

	denseLayer #(
		.NumIn(NumHidden),
		.NumOut(NumOutputs),
		.Weights(OutputWeights),
		.Biases(OutputBiases)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inVector(hiddenVector),
		.outVector(resultVector),
		.outValid(resultValid)
	);

endmodule

`default_nettype wire

// ==== src/apbRegisterFile.sv ====
`default_nettype none

module apbRegisterFile #(
	parameter int NumInputs = 4,
	parameter int NumOutputs = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [nnPkg::AddrWidth-1:0] paddr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [nnPkg::DataWidth-1:0] pwdata,
	input wire logic busy,
	input wire logic done,
	input wire logic [NumOutputs*nnPkg::ActWidth-1:0] outputVector,
	output logic [nnPkg::DataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic startPulse,
	output logic [NumInputs*nnPkg::ActWidth-1:0] inputVector
);

	logic isControl;
	logic isStatus;
	logic isInput;
	logic isOutput;
	logic [1:0] regIndex;
	logic accessError;
	logic writeAccess;
	logic [nnPkg::DataWidth-1:0] readData;

	// Input and output registers sit on consecutive words
	assign regIndex = paddr[3:2];

	always_comb
	begin
		isControl = 1'b0;
		isStatus = 1'b0;
		isInput = 1'b0;
		isOutput = 1'b0;
		case (paddr)
			nnPkg::RegControl:
			begin
				isControl = 1'b1;
			end
			nnPkg::RegStatus:
			begin
				isStatus = 1'b1;
			end
			nnPkg::RegIn0, nnPkg::RegIn1, nnPkg::RegIn2, nnPkg::RegIn3:
			begin
				isInput = int'(regIndex) < NumInputs;
			end
			nnPkg::RegOut0, nnPkg::RegOut1:
			begin
				isOutput = int'(regIndex) < NumOutputs;
			end
			default:
			begin
				isControl = 1'b0;
			end
		endcase
	end

	// Inputs are locked while a vector is in flight
	assign accessError = !(isControl || isStatus || isInput || isOutput)
		|| (pwrite && (isStatus || isOutput))
		|| (pwrite && isInput && busy);

	assign writeAccess = psel && penable && pwrite && !accessError;
	assign pready = 1'b1;
	assign pslverr = psel && penable && accessError;

	always_comb
	begin
		readData = '0;
		if (isStatus)
		begin
			readData[1:0] = {done, busy};
		end
		else if (isInput)
		begin
			readData[nnPkg::ActWidth-1:0] =
				inputVector[regIndex*nnPkg::ActWidth +: nnPkg::ActWidth];
		end
		else if (isOutput)
		begin
			readData[nnPkg::ActWidth-1:0] =
				outputVector[regIndex*nnPkg::ActWidth +: nnPkg::ActWidth];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prdata <= '0;
			startPulse <= 1'b0;
			inputVector <= '0;
		end
		else
		begin
			// A start while busy is dropped quietly
			startPulse <= writeAccess && isControl && pwdata[0] && !busy;
			if (psel && !penable)
			begin
				prdata <= readData;
			end
			if (writeAccess && isInput)
			begin
				inputVector[regIndex*nnPkg::ActWidth +: nnPkg::ActWidth] <=
					pwdata[nnPkg::ActWidth-1:0];
			end
		end
	end

	enableAfterSetup: assert property (@(posedge clk) disable iff (reset)
		penable |-> $past(psel && !penable));

endmodule

`default_nettype wire

// ==== src/inferenceControl.sv ====
`default_nettype none

module inferenceControl #(
	parameter int NumOutputs = 2
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic startPulse,
	input wire logic resultValid,
	input wire logic [NumOutputs*nnPkg::ActWidth-1:0] resultVector,
	output logic launchValid,
	output logic busy,
	output logic done,
	output logic [NumOutputs*nnPkg::ActWidth-1:0] outputVector
);

	nnPkg::ctrlState_t state;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnPkg::Idle;
			done <= 1'b0;
			outputVector <= '0;
		end
		else
		begin
			case (state)
				nnPkg::Idle:
				begin
					if (startPulse)
					begin
						done <= 1'b0;
						state <= nnPkg::Launch;
					end
				end
				nnPkg::Launch:
				begin
					state <= nnPkg::Wait;
				end
				nnPkg::Wait:
				begin
					// The result is taken on its valid edge and Capture then reports done
					if (resultValid)
					begin
						outputVector <= resultVector;
						state <= nnPkg::Capture;
					end
				end
				nnPkg::Capture:
				begin
					done <= 1'b1;
					state <= nnPkg::Idle;
				end
				default:
				begin
					state <= nnPkg::Idle;
				end
			endcase
		end
	end

	assign busy = (state != nnPkg::Idle);
	assign launchValid = (state == nnPkg::Launch);

	singleLaunch: assert property (@(posedge clk) disable iff (reset)
		launchValid |=> !launchValid);

	// Only one vector is ever issued, so a result outside Wait means a lost tag
	resultInWait: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> state == nnPkg::Wait);

endmodule

`default_nettype wire

// ==== src/denseLayer.sv ====
`default_nettype none

module denseLayer #(
	parameter int NumIn = 4,
	parameter int NumOut = 4,
	parameter logic [NumOut-1:0][NumIn-1:0][nnPkg::AccWidth-1:0] Weights = '0,
	parameter logic [NumOut-1:0][nnPkg::AccWidth-1:0] Biases = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic inValid,
	input wire logic [NumIn*nnPkg::ActWidth-1:0] inVector,
	output logic [NumOut*nnPkg::ActWidth-1:0] outVector,
	output logic outValid
);

	logic [nnPkg::LayerLatency-1:0] validPipe;

	// Every neuron sees the same input vector
	for (genvar j = 0; j < NumOut; j++)
	begin : gNeuron
		neuronNode #(
			.NumIn(NumIn),
			.Weights(Weights[j]),
			.Bias(Biases[j])
		) node (
			.clk(clk),
			.reset(reset),
			.activations(inVector),
			.result(outVector[j*nnPkg::ActWidth +: nnPkg::ActWidth])
		);
	end

	// Valid tags move in step with the neuron stages, one bit per vector in flight
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[nnPkg::LayerLatency-2:0], inValid};
		end
	end

	assign outValid = validPipe[nnPkg::LayerLatency-1];

	validLatency: assert property (@(posedge clk) disable iff (reset)
		outValid == $past(inValid, nnPkg::LayerLatency));

endmodule

`default_nettype wire

// ==== src/neuronNode.sv ====
`default_nettype none

module neuronNode #(
	parameter int NumIn = 4,
	parameter logic [NumIn-1:0][nnPkg::AccWidth-1:0] Weights = '0,
	parameter logic [nnPkg::AccWidth-1:0] Bias = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [NumIn*nnPkg::ActWidth-1:0] activations,
	output logic [nnPkg::ActWidth-1:0] result
);

	logic [NumIn-1:0][nnPkg::AccWidth-1:0] actReg;
	logic [nnPkg::AccWidth-1:0] macSum;
	logic [nnPkg::AccWidth-1:0] sumReg;

	// Stage 1 holds the activations already widened to the accumulator width
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
		end
		else
		begin
			for (int i = 0; i < NumIn; i++)
			begin
				actReg[i] <= {{(nnPkg::AccWidth - nnPkg::ActWidth){1'b0}},
					activations[i*nnPkg::ActWidth +: nnPkg::ActWidth]};
			end
		end
	end

	// Products and sum wrap at the accumulator width, so signed weights
	// work without any sign handling here
	always_comb
	begin
		macSum = Bias;
		for (int i = 0; i < NumIn; i++)
		begin
			macSum = macSum + actReg[i] * Weights[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= macSum;
		end
	end

	// Stage 3 is the saturating rectifier
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else if (sumReg[nnPkg::AccWidth-1])
		begin
			result <= '0;
		end
		else if (sumReg >= nnPkg::SatLimit)
		begin
			result <= '1;
		end
		else
		begin
			result <= sumReg[nnPkg::FracShift +: nnPkg::ActWidth];
		end
	end

	resultKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(result));

endmodule

`default_nettype wire

// ==== src/nnPkg.sv ====
`default_nettype none

package nnPkg;

	// Datapath widths
	parameter int ActWidth = 8;
	parameter int AccWidth = 24;

	// APB address and data widths
	parameter int AddrWidth = 8;
	parameter int DataWidth = 32;

	// The rectifier clips sums at or above SatLimit to full scale and otherwise
	// takes the activation from bit FracShift upwards
	parameter int SatLimit = 8192;
	parameter int FracShift = 5;

	// Register stages through one neuron
	parameter int LayerLatency = 3;

	typedef enum logic [AddrWidth-1:0] {
		RegControl = 8'h00,
		RegStatus = 8'h04,
		RegIn0 = 8'h10,
		RegIn1 = 8'h14,
		RegIn2 = 8'h18,
		RegIn3 = 8'h1C,
		RegOut0 = 8'h20,
		RegOut1 = 8'h24
	} regAddr_t;

	typedef enum logic [1:0] {
		Idle,
		Launch,
		Wait,
		Capture
	} ctrlState_t;

endpackage

`default_nettype wire
